// ==== flist.f ====
design/dcache_pkg.sv
design/dcache_ctrl.sv
design/dcache_store.sv
design/dcache_mem_port.sv
design/dcache_top.sv
dv/dcache_checker.sv
dv/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - design/dcache_pkg.sv
  - design/dcache_ctrl.sv
  - design/dcache_store.sv
  - design/dcache_mem_port.sv
  - design/dcache_top.sv
  - target: test
    files:
      - dv/dcache_checker.sv
      - dv/dcache_tb.sv

// ==== dv/dcache_tb.sv ====
// Testbench for the data cache: directed cases, then random reads and writes.
// The memory model answers only word addresses below MEM_WORDS, so all
// stimulus stays inside that range. Inputs change on the falling clock edge.
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

	localparam int MEM_WORDS  = 64;
	localparam int N_DIRECTED = 22;
	localparam int N_RANDOM   = 200;
	localparam int MAX_CYCLES = 40 * (N_DIRECTED + N_RANDOM) + 200;

	logic                clk_i = 1'b0;
	logic                rst_i;
	dcache_pkg::pi_op_t  m_op_i;
	dcache_pkg::addr_t   m_addr_i;
	dcache_pkg::data_t   m_data_i;
	dcache_pkg::sel_t    m_sel_i;
	dcache_pkg::data_t   m_data_o;
	logic                m_rdy_o;
	dcache_pkg::pi_op_t  s_op_o;
	dcache_pkg::addr_t   s_addr_o;
	dcache_pkg::data_t   s_data_o;
	dcache_pkg::sel_t    s_sel_o;
	dcache_pkg::data_t   s_data_i;
	logic                s_rdy_i;

	dcache_pkg::data_t   mem [MEM_WORDS];
	dcache_pkg::addr_t   rd_addr;
	logic                chk_idle;
	int                  mismatch_errs;
	int                  other_errs;
	int                  cycles = 0;

	always #50 clk_i = ~clk_i;

	dcache_top u_dut (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.m_op_i   (m_op_i),
		.m_addr_i (m_addr_i),
		.m_data_i (m_data_i),
		.m_sel_i  (m_sel_i),
		.m_data_o (m_data_o),
		.m_rdy_o  (m_rdy_o),
		.s_op_o   (s_op_o),
		.s_addr_o (s_addr_o),
		.s_data_o (s_data_o),
		.s_sel_o  (s_sel_o),
		.s_data_i (s_data_i),
		.s_rdy_i  (s_rdy_i)
	);

	dcache_checker u_chk (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.m_op_i          (m_op_i),
		.m_addr_i        (m_addr_i),
		.m_data_i        (m_data_i),
		.m_sel_i         (m_sel_i),
		.m_data_o        (m_data_o),
		.m_rdy_o         (m_rdy_o),
		.s_op_o          (s_op_o),
		.s_addr_o        (s_addr_o),
		.s_data_o        (s_data_o),
		.s_sel_o         (s_sel_o),
		.s_rdy_i         (s_rdy_i),
		.idle_o          (chk_idle),
		.mismatch_errs_o (mismatch_errs),
		.other_errs_o    (other_errs)
	);

	function automatic dcache_pkg::data_t init_word(int unsigned a);
		return (32'h9e37_79b9 * (a + 1)) ^ (a << 20);
	endfunction

	// Memory model. A read is answered from the word taken with the last RD.
	always @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= init_word(i);
			rd_addr <= '0;
		end else if (s_op_o == dcache_pkg::OP_WR) begin
			for (int b = 0; b < dcache_pkg::SEL_W; b++)
				if (s_sel_o[b])
					mem[s_addr_o % MEM_WORDS][8*b +: 8] <= s_data_o[8*b +: 8];
		end else if (s_op_o == dcache_pkg::OP_RD) begin
			rd_addr <= s_addr_o;
		end
	end

	initial begin
		s_rdy_i  = 1'b0;
		s_data_i = '0;
		forever begin
			@(negedge clk_i);
			s_rdy_i  = ($urandom % 4) != 0;
			s_data_i = mem[rd_addr % MEM_WORDS];
		end
	end

	// Holds the request until m_rdy_o is high, so the next rising edge takes it.
	task automatic issue(input dcache_pkg::pi_op_t op, input dcache_pkg::addr_t addr,
			input dcache_pkg::data_t data, input dcache_pkg::sel_t sel);
		@(negedge clk_i);
		m_op_i   = op;
		m_addr_i = addr;
		m_data_i = data;
		m_sel_i  = sel;
		while (!m_rdy_o)
			@(negedge clk_i);
	endtask

	task automatic idle_cycle();
		@(negedge clk_i);
		m_op_i = dcache_pkg::OP_NOOP;
	endtask

	initial begin
		dcache_pkg::pi_op_t op;
		rst_i    = 1'b1;
		m_op_i   = dcache_pkg::OP_NOOP;
		m_addr_i = '0;
		m_data_i = '0;
		m_sel_i  = '0;
		void'($urandom(32'h6c58));
		repeat (10) @(negedge clk_i);
		rst_i = 1'b0;
		// First reads fetch, repeats with fewer bytes must hit.
		for (int a = 0; a < 4; a++)
			issue(dcache_pkg::OP_RD, a, '0, 4'hf);
		for (int a = 0; a < 4; a++)
			issue(dcache_pkg::OP_RD, a, '0, 4'h3);
		// Partial write, forwarded read, then a read of bytes not yet valid.
		issue(dcache_pkg::OP_WR, 'h15, 32'h1234_5678, 4'h3);
		issue(dcache_pkg::OP_RD, 'h15, '0, 4'h3);
		issue(dcache_pkg::OP_RD, 'h15, '0, 4'hc);
		// Another tag in set 5 replaces the line.
		issue(dcache_pkg::OP_WR, 'h25, 32'hcafe_f00d, 4'h1);
		issue(dcache_pkg::OP_RD, 'h15, '0, 4'h1);
		// A burst longer than the write buffer.
		for (int i = 0; i < 8; i++)
			issue(dcache_pkg::OP_WR, 'h30 + i, 32'ha5a5_0000 + i, 4'hf);
		issue(dcache_pkg::OP_RD, 'h30, '0, 4'hf);
		for (int n = 0; n < N_RANDOM; n++) begin
			op = ($urandom % 2) ? dcache_pkg::OP_WR : dcache_pkg::OP_RD;
			issue(op, dcache_pkg::addr_t'($urandom % MEM_WORDS), dcache_pkg::data_t'($urandom),
				dcache_pkg::sel_t'($urandom % 15 + 1));
			if ($urandom % 4 == 0)
				idle_cycle();
		end
		idle_cycle();
		while (!chk_idle)
			@(negedge clk_i);
		$display("Errors: %0d value mismatches, %0d other failures", mismatch_errs, other_errs);
		if (mismatch_errs == 0 && other_errs == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout reached after %0d cycles with the test still running", cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== dv/dcache_checker.sv ====
// Monitor for the data cache ports, sampled on the rising clock edge.
// Addresses must stay below MEM_WORDS, and every read needs a nonzero select.
// Keeps a shadow memory and a tag and valid model per set.
`timescale 1ns/1ps
`default_nettype none

module dcache_checker (
	input  wire                     clk_i,
	input  wire                     rst_i,
	input  wire dcache_pkg::pi_op_t m_op_i,
	input  wire dcache_pkg::addr_t  m_addr_i,
	input  wire dcache_pkg::data_t  m_data_i,
	input  wire dcache_pkg::sel_t   m_sel_i,
	input  wire dcache_pkg::data_t  m_data_o,
	input  wire                     m_rdy_o,
	input  wire dcache_pkg::pi_op_t s_op_o,
	input  wire dcache_pkg::addr_t  s_addr_o,
	input  wire dcache_pkg::data_t  s_data_o,
	input  wire dcache_pkg::sel_t   s_sel_o,
	input  wire                     s_rdy_i,
	output logic                    idle_o,
	output int                      mismatch_errs_o,
	output int                      other_errs_o
);

	localparam int MEM_WORDS = 64;

	dcache_pkg::data_t    shadow   [MEM_WORDS];
	dcache_pkg::tag_t     set_tag  [dcache_pkg::SET_COUNT];
	dcache_pkg::sel_t     set_mask [dcache_pkg::SET_COUNT];

	// Memory-side requests still expected, in acceptance order.
	dcache_pkg::pi_op_t   exp_op_q   [$];
	dcache_pkg::addr_t    exp_addr_q [$];
	dcache_pkg::data_t    exp_data_q [$];
	dcache_pkg::sel_t     exp_sel_q  [$];

	logic                 rd_wait;
	dcache_pkg::data_t    rd_exp;
	dcache_pkg::sel_t     rd_sel;
	int                   since_rst;

	function automatic dcache_pkg::data_t init_word(int unsigned a);
		return (32'h9e37_79b9 * (a + 1)) ^ (a << 20);
	endfunction

	function automatic dcache_pkg::data_t sel_to_mask(dcache_pkg::sel_t sel);
		dcache_pkg::data_t m;
		m = '0;
		for (int b = 0; b < dcache_pkg::SEL_W; b++)
			if (sel[b])
				m[8*b +: 8] = 8'hff;
		return m;
	endfunction

	// Reference result of a read: the selected bytes of the shadow word.
	function automatic dcache_pkg::data_t expected_read(dcache_pkg::addr_t a,
			dcache_pkg::sel_t sel);
		return shadow[a % MEM_WORDS] & sel_to_mask(sel);
	endfunction

	task automatic show_mismatch(input string sig, input logic [63:0] got,
			input logic [63:0] exp);
		$display("ERR %0t %s got %0h expected %0h", $time, sig, got, exp);
		mismatch_errs_o++;
	endtask

	task automatic check_mem_op();
		dcache_pkg::pi_op_t op;
		dcache_pkg::addr_t  a;
		dcache_pkg::data_t  d;
		dcache_pkg::sel_t   sel;
		if (exp_op_q.size() == 0) begin
			$display("Memory request at %0t that no write or read miss explains", $time);
			other_errs_o++;
		end else begin
			op  = exp_op_q.pop_front();
			a   = exp_addr_q.pop_front();
			d   = exp_data_q.pop_front();
			sel = exp_sel_q.pop_front();
			if (s_op_o !== op)
				show_mismatch("s_op_o", s_op_o, op);
			if (s_addr_o !== a)
				show_mismatch("s_addr_o", s_addr_o, a);
			if (op == dcache_pkg::OP_WR && s_data_o !== d)
				show_mismatch("s_data_o", s_data_o, d);
			if (s_sel_o !== sel)
				show_mismatch("s_sel_o", s_sel_o, sel);
		end
	endtask

	task automatic expect_mem_op(input dcache_pkg::pi_op_t op, input dcache_pkg::addr_t a,
			input dcache_pkg::data_t d, input dcache_pkg::sel_t sel);
		exp_op_q.push_back(op);
		exp_addr_q.push_back(a);
		exp_data_q.push_back(d);
		exp_sel_q.push_back(sel);
	endtask

	initial begin
		for (int i = 0; i < MEM_WORDS; i++)
			shadow[i] = init_word(i);
		for (int s = 0; s < dcache_pkg::SET_COUNT; s++) begin
			set_tag[s]  = '0;
			set_mask[s] = '0;
		end
		rd_wait         = 1'b0;
		since_rst       = 0;
		idle_o          = 1'b0;
		mismatch_errs_o = 0;
		other_errs_o    = 0;
	end

	always @(posedge clk_i) begin
		dcache_pkg::set_idx_t s;
		dcache_pkg::tag_t     t;
		dcache_pkg::data_t    m;
		s = m_addr_i[dcache_pkg::SET_W-1:0];
		t = m_addr_i[dcache_pkg::ADDR_W-1:dcache_pkg::SET_W];
		m = sel_to_mask(m_sel_i);
		if (rst_i) begin
			since_rst = 0;
			if (s_op_o !== dcache_pkg::OP_NOOP)
				show_mismatch("s_op_o", s_op_o, dcache_pkg::OP_NOOP);
		end else begin
			if (since_rst < dcache_pkg::SET_COUNT && m_rdy_o) begin
				$display("m_rdy_o rose at %0t before the line sweep could finish", $time);
				other_errs_o++;
			end
			since_rst++;
			if (!s_rdy_i && s_op_o !== dcache_pkg::OP_NOOP)
				show_mismatch("s_op_o", s_op_o, dcache_pkg::OP_NOOP);
			else if (s_op_o !== dcache_pkg::OP_NOOP)
				check_mem_op();
			// The read result is due at the first cycle with m_rdy_o high.
			if (rd_wait && m_rdy_o) begin
				if ((m_data_o & sel_to_mask(rd_sel)) !== rd_exp)
					show_mismatch("m_data_o", m_data_o & sel_to_mask(rd_sel), rd_exp);
				rd_wait = 1'b0;
			end
			if (m_rdy_o && m_op_i == dcache_pkg::OP_WR) begin
				shadow[m_addr_i % MEM_WORDS] = (shadow[m_addr_i % MEM_WORDS] & ~m) |
					(m_data_i & m);
				set_mask[s] = (set_tag[s] == t) ? (set_mask[s] | m_sel_i) : m_sel_i;
				set_tag[s]  = t;
				expect_mem_op(dcache_pkg::OP_WR, m_addr_i, m_data_i, m_sel_i);
			end else if (m_rdy_o && m_op_i == dcache_pkg::OP_RD) begin
				rd_wait = 1'b1;
				rd_sel  = m_sel_i;
				rd_exp  = expected_read(m_addr_i, m_sel_i);
				if (set_tag[s] != t || (m_sel_i & ~set_mask[s]) != '0) begin
					expect_mem_op(dcache_pkg::OP_RD, m_addr_i, '0, '1);
					set_tag[s]  = t;
					set_mask[s] = '1;
				end
			end
		end
		idle_o <= (exp_op_q.size() == 0) && !rd_wait;
	end

endmodule

`default_nettype wire

// ==== design/dcache_top.sv ====
// Direct-mapped write-through data cache with a posted write buffer.
// Master reads return the whole line word; bytes outside m_sel_i are undefined.
// The memory port must hold s_rdy_i low to stall; requests are never retracted.
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
	input  wire                      clk_i,
	input  wire                      rst_i,

	input  wire dcache_pkg::pi_op_t  m_op_i,
	input  wire dcache_pkg::addr_t   m_addr_i,
	input  wire dcache_pkg::data_t   m_data_i,
	input  wire dcache_pkg::sel_t    m_sel_i,
	output dcache_pkg::data_t        m_data_o,
	output logic                     m_rdy_o,

	output dcache_pkg::pi_op_t       s_op_o,
	output dcache_pkg::addr_t        s_addr_o,
	output dcache_pkg::data_t        s_data_o,
	output dcache_pkg::sel_t         s_sel_o,
	input  wire dcache_pkg::data_t   s_data_i,
	input  wire                      s_rdy_i
);

	dcache_pkg::addr_t    req_addr;
	dcache_pkg::data_t    req_data;
	dcache_pkg::sel_t     req_sel;
	dcache_pkg::buf_cnt_t buf_cnt;
	logic                 push;
	logic                 look;
	logic                 rd_issue;
	logic                 fill;
	logic                 rd_taken;
	logic                 rd_done;
	logic                 hit;
	logic                 sweep_done;

	dcache_ctrl u_ctrl (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.m_op_i     (m_op_i),
		.m_addr_i   (m_addr_i),
		.m_data_i   (m_data_i),
		.m_sel_i    (m_sel_i),
		.m_rdy_o    (m_rdy_o),
		.hit        (hit),
		.sweep_done (sweep_done),
		.buf_cnt    (buf_cnt),
		.rd_taken   (rd_taken),
		.rd_done    (rd_done),
		.req_addr   (req_addr),
		.req_data   (req_data),
		.req_sel    (req_sel),
		.push       (push),
		.look       (look),
		.rd_issue   (rd_issue),
		.fill       (fill)
	);

	dcache_store u_store (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.m_addr_i   (m_addr_i),
		.look       (look),
		.req_addr   (req_addr),
		.req_data   (req_data),
		.req_sel    (req_sel),
		.push       (push),
		.fill       (fill),
		.s_data_i   (s_data_i),
		.hit        (hit),
		.line_data  (),
		.m_data_o   (m_data_o),
		.sweep_done (sweep_done)
	);

	dcache_mem_port u_mem_port (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.push     (push),
		.req_addr (req_addr),
		.req_data (req_data),
		.req_sel  (req_sel),
		.rd_issue (rd_issue),
		.s_rdy_i  (s_rdy_i),
		.buf_cnt  (buf_cnt),
		.rd_taken (rd_taken),
		.rd_done  (rd_done),
		.s_op_o   (s_op_o),
		.s_addr_o (s_addr_o),
		.s_data_o (s_data_o),
		.s_sel_o  (s_sel_o)
	);

endmodule

`default_nettype wire

// ==== design/dcache_mem_port.sv ====
// Posted write buffer and memory-side request mux.
// Writes drain in order; the miss fetch goes out only with the buffer empty.
// One read may be in flight and its data is taken at the next s_rdy_i.
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_port (
	input  wire                     clk_i,
	input  wire                     rst_i,
	input  wire                     push,
	input  wire dcache_pkg::addr_t  req_addr,
	input  wire dcache_pkg::data_t  req_data,
	input  wire dcache_pkg::sel_t   req_sel,
	input  wire                     rd_issue,
	input  wire                     s_rdy_i,
	output dcache_pkg::buf_cnt_t    buf_cnt,
	output logic                    rd_taken,
	output logic                    rd_done,
	output dcache_pkg::pi_op_t      s_op_o,
	output dcache_pkg::addr_t       s_addr_o,
	output dcache_pkg::data_t       s_data_o,
	output dcache_pkg::sel_t        s_sel_o
);

	dcache_pkg::addr_t addr_mem [dcache_pkg::BUF_DEPTH];
	dcache_pkg::data_t data_mem [dcache_pkg::BUF_DEPTH];
	dcache_pkg::sel_t  sel_mem  [dcache_pkg::BUF_DEPTH];

	logic [$clog2(dcache_pkg::BUF_DEPTH)-1:0] wr_ptr;
	logic [$clog2(dcache_pkg::BUF_DEPTH)-1:0] rd_ptr;
	logic                                     rd_inflight;
	logic                                     pop;
	logic                                     buf_empty;

	assign buf_empty = (buf_cnt == '0);

	always_comb begin
		s_op_o   = dcache_pkg::OP_NOOP;
		s_addr_o = addr_mem[rd_ptr];
		s_data_o = data_mem[rd_ptr];
		s_sel_o  = sel_mem[rd_ptr];
		if (s_rdy_i && !rd_inflight) begin
			if (!buf_empty) begin
				s_op_o = dcache_pkg::OP_WR;
			end else if (rd_issue) begin
				s_op_o   = dcache_pkg::OP_RD;
				s_addr_o = req_addr;
				s_sel_o  = '1;
			end
		end
	end

	assign pop      = (s_op_o == dcache_pkg::OP_WR);
	assign rd_taken = (s_op_o == dcache_pkg::OP_RD);
	assign rd_done  = rd_inflight && s_rdy_i;

	always_ff @(posedge clk_i) begin
		if (push) begin
			addr_mem[wr_ptr] <= req_addr;
			data_mem[wr_ptr] <= req_data;
			sel_mem[wr_ptr]  <= req_sel;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			buf_cnt     <= '0;
			rd_inflight <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				buf_cnt <= buf_cnt + 1'b1;
			else if (pop && !push)
				buf_cnt <= buf_cnt - 1'b1;
			if (rd_taken)
				rd_inflight <= 1'b1;
			else if (rd_done)
				rd_inflight <= 1'b0;
		end
	end

	a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
		push |-> (buf_cnt != dcache_pkg::buf_cnt_t'(dcache_pkg::BUF_DEPTH)));

	// The fetch must follow every earlier write, including one not yet pushed.
	a_rd_after_wr: assert property (@(posedge clk_i) disable iff (rst_i)
		(s_op_o == dcache_pkg::OP_RD) |-> (buf_empty && !push));

endmodule

`default_nettype wire

// ==== design/dcache_store.sv ====
// Line store with tag, data and per-byte valid arrays, one line per set.
// Lookup is registered at read acceptance and the hit test runs the cycle after.
// A line written at the same edge as a lookup of its set is forwarded.
// Valid masks are cleared by a sweep of SET_COUNT cycles after reset.
`timescale 1ns/1ps
`default_nettype none

module dcache_store (
	input  wire                     clk_i,
	input  wire                     rst_i,
	input  wire dcache_pkg::addr_t  m_addr_i,
	input  wire                     look,
	input  wire dcache_pkg::addr_t  req_addr,
	input  wire dcache_pkg::data_t  req_data,
	input  wire dcache_pkg::sel_t   req_sel,
	input  wire                     push,
	input  wire                     fill,
	input  wire dcache_pkg::data_t  s_data_i,
	output logic                    hit,
	output dcache_pkg::data_t       line_data,
	output dcache_pkg::data_t       m_data_o,
	output logic                    sweep_done
);

	dcache_pkg::tag_t     tag_mem  [dcache_pkg::SET_COUNT];
	dcache_pkg::data_t    data_mem [dcache_pkg::SET_COUNT];
	dcache_pkg::sel_t     mask_mem [dcache_pkg::SET_COUNT];

	dcache_pkg::set_idx_t wr_set;
	dcache_pkg::tag_t     wr_tag;
	dcache_pkg::set_idx_t lk_set;
	dcache_pkg::sel_t     line_mask;
	logic                 wr_en;
	logic                 tag_match;

	dcache_pkg::tag_t     rd_tag_q;
	dcache_pkg::data_t    rd_data_q;
	dcache_pkg::sel_t     rd_mask_q;

	logic                 sweep_active;
	dcache_pkg::set_idx_t sweep_idx;

	assign wr_set    = req_addr[dcache_pkg::SET_W-1:0];
	assign wr_tag    = req_addr[dcache_pkg::ADDR_W-1:dcache_pkg::SET_W];
	assign lk_set    = m_addr_i[dcache_pkg::SET_W-1:0];
	assign wr_en     = push || fill;
	assign tag_match = (tag_mem[wr_set] == wr_tag);

	// New line word for a write merge or a fill.
	always_comb begin
		if (fill) begin
			line_data = s_data_i;
		end else begin
			line_data = data_mem[wr_set];
			for (int b = 0; b < dcache_pkg::SEL_W; b++) begin
				if (req_sel[b])
					line_data[8*b +: 8] = req_data[8*b +: 8];
			end
		end
	end

	// A write to another tag replaces the line, so only its own bytes stay valid.
	always_comb begin
		if (fill)
			line_mask = '1;
		else if (tag_match)
			line_mask = mask_mem[wr_set] | req_sel;
		else
			line_mask = req_sel;
	end

	always_ff @(posedge clk_i) begin
		if (wr_en) begin
			tag_mem[wr_set]  <= wr_tag;
			data_mem[wr_set] <= line_data;
		end
		if (sweep_active)
			mask_mem[sweep_idx] <= '0;
		else if (wr_en)
			mask_mem[wr_set] <= line_mask;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			sweep_active <= 1'b1;
			sweep_idx    <= '0;
		end else if (sweep_active) begin
			sweep_idx <= sweep_idx + 1'b1;
			if (sweep_idx == dcache_pkg::set_idx_t'(dcache_pkg::SET_COUNT - 1))
				sweep_active <= 1'b0;
		end
	end

	// The lookup register takes the new line when that set is written at the
	// same edge, and always on a fill so the fetched word reaches m_data_o.
	always_ff @(posedge clk_i) begin
		if (fill || (look && wr_en && (lk_set == wr_set))) begin
			rd_tag_q  <= wr_tag;
			rd_data_q <= line_data;
			rd_mask_q <= line_mask;
		end else if (look) begin
			rd_tag_q  <= tag_mem[lk_set];
			rd_data_q <= data_mem[lk_set];
			rd_mask_q <= mask_mem[lk_set];
		end
	end

	assign hit = (rd_tag_q == req_addr[dcache_pkg::ADDR_W-1:dcache_pkg::SET_W]) &&
		((req_sel & ~rd_mask_q) == '0);
	assign m_data_o   = rd_data_q;
	assign sweep_done = !sweep_active;

	// A fetch can only start once the master has been released after the sweep.
	a_no_fill_in_sweep: assert property (@(posedge clk_i) disable iff (rst_i)
		sweep_active |-> !fill);

endmodule

`default_nettype wire

// ==== design/dcache_ctrl.sv ====
// Cache controller FSM with master handshake, request hold and miss sequencing.
// Opcodes other than OP_WR and OP_RD are ignored.
// A write is pushed one cycle after acceptance, so m_rdy_o also counts
// a push that is still pending when judging the buffer full.
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
	input  wire                       clk_i,
	input  wire                       rst_i,
	input  wire dcache_pkg::pi_op_t   m_op_i,
	input  wire dcache_pkg::addr_t    m_addr_i,
	input  wire dcache_pkg::data_t    m_data_i,
	input  wire dcache_pkg::sel_t     m_sel_i,
	output logic                      m_rdy_o,
	input  wire                       hit,
	input  wire                       sweep_done,
	input  wire dcache_pkg::buf_cnt_t buf_cnt,
	input  wire                       rd_taken,
	input  wire                       rd_done,
	output dcache_pkg::addr_t         req_addr,
	output dcache_pkg::data_t         req_data,
	output dcache_pkg::sel_t          req_sel,
	output logic                      push,
	output logic                      look,
	output logic                      rd_issue,
	output logic                      fill
);

	dcache_pkg::ctrl_state_e state;
	logic                    rd_pend;
	logic                    miss;
	logic                    buf_full;
	logic                    wr_acc;

	// A read accepted last cycle that missed pulls m_rdy_o low at once.
	assign miss     = rd_pend && !hit;
	assign buf_full = (buf_cnt == dcache_pkg::buf_cnt_t'(dcache_pkg::BUF_DEPTH)) ||
		(push && (buf_cnt == dcache_pkg::buf_cnt_t'(dcache_pkg::BUF_DEPTH - 1)));
	assign m_rdy_o  = (state == dcache_pkg::IDLE) && !miss && !buf_full;

	assign wr_acc   = m_rdy_o && (m_op_i == dcache_pkg::OP_WR);
	assign look     = m_rdy_o && (m_op_i == dcache_pkg::OP_RD);
	assign rd_issue = (state == dcache_pkg::MISS_REQ);
	assign fill     = (state == dcache_pkg::MISS_WAIT) && rd_done;

	always_ff @(posedge clk_i) begin
		if (wr_acc || look) begin
			req_addr <= m_addr_i;
			req_data <= m_data_i;
			req_sel  <= m_sel_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			push    <= 1'b0;
			rd_pend <= 1'b0;
		end else begin
			push    <= wr_acc;
			rd_pend <= look;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= dcache_pkg::SWEEP;
		end else begin
			unique case (state)
				dcache_pkg::SWEEP:      if (sweep_done) state <= dcache_pkg::IDLE;
				dcache_pkg::IDLE:       if (miss) state <= dcache_pkg::MISS_DRAIN;
				// The fetch must see every posted write first.
				dcache_pkg::MISS_DRAIN: if (buf_cnt == '0) state <= dcache_pkg::MISS_REQ;
				dcache_pkg::MISS_REQ:   if (rd_taken) state <= dcache_pkg::MISS_WAIT;
				dcache_pkg::MISS_WAIT:  if (rd_done) state <= dcache_pkg::IDLE;
				default:                state <= dcache_pkg::SWEEP;
			endcase
		end
	end

	// Pushes come only from IDLE and the fetch only from MISS_REQ.
	a_push_vs_read: assert property (@(posedge clk_i) disable iff (rst_i)
		!(push && rd_issue));

	// The master sees no readiness until the line store has finished its sweep.
	a_rdy_in_sweep: assert property (@(posedge clk_i) disable iff (rst_i)
		(!sweep_done || state == dcache_pkg::SWEEP) |-> !m_rdy_o);

endmodule

`default_nettype wire

// ==== design/dcache_pkg.sv ====
// Sizes, vector types and encodings shared by the data cache.
// The data path is fixed at 32 bits with byte selects.
// SET_W must be log2 of SET_COUNT and BUF_DEPTH must be a power of two.
`default_nettype none

package dcache_pkg;

	localparam int DATA_W    = 32;
	localparam int SEL_W     = DATA_W / 8;
	localparam int ADDR_W    = 30;
	localparam int SET_COUNT = 16;
	localparam int SET_W     = 4;
	localparam int TAG_W     = ADDR_W - SET_W;
	localparam int BUF_DEPTH = 4;

	typedef logic [DATA_W-1:0]                data_t;
	typedef logic [SEL_W-1:0]                 sel_t;
	typedef logic [ADDR_W-1:0]                addr_t;
	typedef logic [SET_W-1:0]                 set_idx_t;
	typedef logic [TAG_W-1:0]                 tag_t;
	typedef logic [$clog2(BUF_DEPTH+1)-1:0]   buf_cnt_t;
	typedef logic [1:0]                       pi_op_t;

	// Memory port operation codes.
	localparam pi_op_t OP_NOOP = 2'b00;
	localparam pi_op_t OP_WR   = 2'b01;
	localparam pi_op_t OP_RD   = 2'b10;

	// Controller states; SWEEP is entered on reset.
	typedef enum logic [2:0] {
		SWEEP,
		IDLE,
		MISS_DRAIN,
		MISS_REQ,
		MISS_WAIT
	} ctrl_state_e;

endpackage

`default_nettype wire
